// ==== hdl/dot_product_engine.sv ====
`default_nettype none

`include "matmul_config.svh"

module dot_product_engine (
    input  wire logic                                clk,
    input  wire logic                                rst,
    input  wire logic                                operands_ready,
    input  wire matmul_pkg::elem_t                   op_rd_data,
    output logic [$clog2(`MATMUL_OPERAND_COUNT)-1:0] op_rd_addr,
    output logic                                     res_wr,
    output logic [$clog2(`MATMUL_RESULT_COUNT)-1:0]  res_wr_addr,
    output matmul_pkg::result_t                      res_wr_data,
    output logic                                     results_ready
);

    localparam int RES_AW = $clog2(`MATMUL_RESULT_COUNT);
    localparam int PROD_W = 2 * `MATMUL_ELEM_W;
    localparam logic [RES_AW-1:0] LAST_ELEM = RES_AW'(`MATMUL_DIM * `MATMUL_DIM - 1);
    // phases 0..3 fetch operands, phase 4 writes the element
    localparam logic [2:0] WRITE_PHASE = 3'd4;

    logic              busy;
    logic [2:0]        phase;
    logic [RES_AW-1:0] elem;
    logic              row;
    logic              col;
    matmul_pkg::elem_t a0;
    matmul_pkg::elem_t a1;
    matmul_pkg::elem_t b0;
    matmul_pkg::elem_t b1;
    logic [PROD_W-1:0] prod0;
    logic [PROD_W-1:0] prod1;

    // element index is row-major, so 2i+j
    assign row = elem[1];
    assign col = elem[0];

    // A(i,0), A(i,1), B(0,j), B(1,j)
    always_comb begin
        case (phase)
            3'd0:    op_rd_addr = {1'b0, row, 1'b0};
            3'd1:    op_rd_addr = {1'b0, row, 1'b1};
            3'd2:    op_rd_addr = {1'b1, 1'b0, col};
            3'd3:    op_rd_addr = {1'b1, 1'b1, col};
            default: op_rd_addr = '0;
        endcase
    end

    // operands latched one per fetch phase
    always_ff @(posedge clk) begin
        if (busy) begin
            case (phase)
                3'd0:    a0 <= op_rd_data;
                3'd1:    a1 <= op_rd_data;
                3'd2:    b0 <= op_rd_data;
                3'd3:    b1 <= op_rd_data;
                default: begin
                end
            endcase
        end
    end

    assign prod0       = a0 * b0;
    assign prod1       = a1 * b1;
    assign res_wr      = busy && (phase == WRITE_PHASE);
    assign res_wr_addr = elem;
    assign res_wr_data = matmul_pkg::result_t'(prod0) + matmul_pkg::result_t'(prod1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy          <= 1'b0;
            phase         <= '0;
            elem          <= '0;
            results_ready <= 1'b0;
        end else begin
            // one cycle after the write of C11
            results_ready <= res_wr && (elem == LAST_ELEM);
            if (!busy) begin
                phase <= '0;
                elem  <= '0;
                if (operands_ready) begin
                    busy <= 1'b1;
                end
            end else if (phase == WRITE_PHASE) begin
                phase <= '0;
                elem  <= elem + 1'b1;
                if (elem == LAST_ELEM) begin
                    busy <= 1'b0;
                end
            end else begin
                phase <= phase + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/matmul_config.svh ====
`ifndef MATMUL_CONFIG_SVH
`define MATMUL_CONFIG_SVH

// operand width, one byte per link transfer
`define MATMUL_ELEM_W 8

// 2*255*255 = 130050 needs 17 bits, one spare
`define MATMUL_RESULT_W 18

// square matrix size
`define MATMUL_DIM 2

// A at 0..3, B at 4..7, both row-major
`define MATMUL_OPERAND_COUNT 8

// C row-major
`define MATMUL_RESULT_COUNT 4

`endif

// ==== hdl/matmul_pkg.sv ====
`default_nettype none

`include "matmul_config.svh"

package matmul_pkg;

    // one operand byte from the link
    typedef logic [`MATMUL_ELEM_W-1:0] elem_t;

    // one element of C = A*B
    typedef logic [`MATMUL_RESULT_W-1:0] result_t;

endpackage

`default_nettype wire

// ==== hdl/matmul_top.sv ====
`default_nettype none

`include "matmul_config.svh"

module matmul_top (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                rx_valid,
    input  wire matmul_pkg::elem_t   rx_data,
    input  wire logic                tx_ready,
    output matmul_pkg::result_t      tx_data,
    output logic                     load,
    output logic                     done
);

    // operand side
    logic                                     op_wr;
    logic [$clog2(`MATMUL_OPERAND_COUNT)-1:0] op_wr_addr;
    matmul_pkg::elem_t                        op_wr_data;
    logic                                     operands_ready;
    logic [$clog2(`MATMUL_OPERAND_COUNT)-1:0] op_rd_addr;
    matmul_pkg::elem_t                        op_rd_data;

    // result side
    logic                                     res_wr;
    logic [$clog2(`MATMUL_RESULT_COUNT)-1:0]  res_wr_addr;
    matmul_pkg::result_t                      res_wr_data;
    logic                                     results_ready;
    logic [$clog2(`MATMUL_RESULT_COUNT)-1:0]  res_rd_addr;
    matmul_pkg::result_t                      res_rd_data;

    operand_loader operand_loader_i (
        .clk            (clk),
        .rst            (rst),
        .rx_valid       (rx_valid),
        .rx_data        (rx_data),
        .done           (done),
        .wr             (op_wr),
        .wr_addr        (op_wr_addr),
        .wr_data        (op_wr_data),
        .operands_ready (operands_ready)
    );

    matrix_store #(
        .DEPTH     (`MATMUL_OPERAND_COUNT),
        .elem_type (matmul_pkg::elem_t)
    ) operand_store_i (
        .clk     (clk),
        .rst     (rst),
        .wr      (op_wr),
        .wr_addr (op_wr_addr),
        .wr_data (op_wr_data),
        .rd_addr (op_rd_addr),
        .rd_data (op_rd_data)
    );

    dot_product_engine dot_product_engine_i (
        .clk            (clk),
        .rst            (rst),
        .operands_ready (operands_ready),
        .op_rd_data     (op_rd_data),
        .op_rd_addr     (op_rd_addr),
        .res_wr         (res_wr),
        .res_wr_addr    (res_wr_addr),
        .res_wr_data    (res_wr_data),
        .results_ready  (results_ready)
    );

    matrix_store #(
        .DEPTH     (`MATMUL_RESULT_COUNT),
        .elem_type (matmul_pkg::result_t)
    ) result_store_i (
        .clk     (clk),
        .rst     (rst),
        .wr      (res_wr),
        .wr_addr (res_wr_addr),
        .wr_data (res_wr_data),
        .rd_addr (res_rd_addr),
        .rd_data (res_rd_data)
    );

    result_sender result_sender_i (
        .clk           (clk),
        .rst           (rst),
        .results_ready (results_ready),
        .res_rd_data   (res_rd_data),
        .tx_ready      (tx_ready),
        .res_rd_addr   (res_rd_addr),
        .tx_data       (tx_data),
        .load          (load),
        .done          (done)
    );

endmodule

`default_nettype wire

// ==== hdl/matrix_store.sv ====
`default_nettype none

module matrix_store #(
    parameter int  DEPTH     = 8,
    parameter type elem_type = logic [7:0]
) (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic                     wr,
    input  wire logic [$clog2(DEPTH)-1:0] wr_addr,
    input  wire elem_type                 wr_data,
    input  wire logic [$clog2(DEPTH)-1:0] rd_addr,
    output elem_type                      rd_data
);

    elem_type mem [DEPTH];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (wr) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // read is combinational, same cycle as the address
    assign rd_data = mem[rd_addr];

endmodule

`default_nettype wire

// ==== hdl/operand_loader.sv ====
`default_nettype none

`include "matmul_config.svh"

module operand_loader (
    input  wire logic                                clk,
    input  wire logic                                rst,
    input  wire logic                                rx_valid,
    input  wire matmul_pkg::elem_t                   rx_data,
    input  wire logic                                done,
    output logic                                     wr,
    output logic [$clog2(`MATMUL_OPERAND_COUNT)-1:0] wr_addr,
    output matmul_pkg::elem_t                        wr_data,
    output logic                                     operands_ready
);

    localparam int AW = $clog2(`MATMUL_OPERAND_COUNT);
    localparam logic [AW-1:0] LAST_ADDR = AW'(`MATMUL_OPERAND_COUNT - 1);

    logic          rx_valid_q;
    logic          strobe;
    logic          armed;
    logic [AW-1:0] count;

    // one byte per low-to-high change of rx_valid
    assign strobe = rx_valid && !rx_valid_q;

    // bytes outside a collection window are dropped
    assign wr             = armed && strobe;
    assign wr_addr        = count;
    assign wr_data        = rx_data;
    assign operands_ready = wr && (count == LAST_ADDR);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rx_valid_q <= 1'b0;
            armed      <= 1'b1;
            count      <= '0;
        end else begin
            rx_valid_q <= rx_valid;
            if (operands_ready) begin
                count <= '0;
                armed <= 1'b0;
            end else begin
                if (wr) begin
                    count <= count + 1'b1;
                end
                // re-arm once the result side has finished
                if (done) begin
                    armed <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/result_sender.sv ====
`default_nettype none

`include "matmul_config.svh"

module result_sender (
    input  wire logic                               clk,
    input  wire logic                               rst,
    input  wire logic                               results_ready,
    input  wire matmul_pkg::result_t                res_rd_data,
    input  wire logic                               tx_ready,
    output logic [$clog2(`MATMUL_RESULT_COUNT)-1:0] res_rd_addr,
    output matmul_pkg::result_t                     tx_data,
    output logic                                    load,
    output logic                                    done
);

    localparam int AW = $clog2(`MATMUL_RESULT_COUNT);
    localparam logic [AW-1:0] LAST_IDX = AW'(`MATMUL_RESULT_COUNT - 1);

    typedef enum logic [1:0] {
        s_idle,
        s_wait_ready,
        s_wait_drop,
        s_wait_rise
    } state_t;

    state_t        state;
    logic [AW-1:0] idx;

    assign res_rd_addr = idx;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= s_idle;
            idx     <= '0;
            load    <= 1'b0;
            tx_data <= '0;
            done    <= 1'b0;
        end else begin
            // pulses by default, tx_data only valid with load
            load    <= 1'b0;
            tx_data <= '0;
            done    <= 1'b0;
            case (state)
                s_idle: begin
                    if (results_ready) begin
                        idx   <= '0;
                        state <= s_wait_ready;
                    end
                end
                s_wait_ready: begin
                    if (tx_ready) begin
                        load    <= 1'b1;
                        tx_data <= res_rd_data;
                        state   <= s_wait_drop;
                    end
                end
                // transmitter busy with the byte just handed over
                s_wait_drop: begin
                    if (!tx_ready) begin
                        state <= s_wait_rise;
                    end
                end
                s_wait_rise: begin
                    if (tx_ready) begin
                        if (idx == LAST_IDX) begin
                            done  <= 1'b1;
                            state <= s_idle;
                        end else begin
                            idx   <= idx + 1'b1;
                            state <= s_wait_ready;
                        end
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== matmul.f ====
+incdir+hdl
hdl/matmul_pkg.sv
hdl/matrix_store.sv
hdl/operand_loader.sv
hdl/dot_product_engine.sv
hdl/result_sender.sv
hdl/matmul_top.sv
verification/matmul_sva.sv
verification/matmul_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# compile and run the matmul testbench, verdict comes from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert --timescale 1ns/1ps --top-module matmul_tb \
    -f matmul.f -o matmul_sim \
    && ./obj_dir/matmul_sim > sim.log 2>&1

cat sim.log 2>/dev/null
grep -q "=== PASS ===" sim.log 2>/dev/null && echo "result: pass" && exit 0 \
    || echo "result: fail"
exit 1

// ==== verification/matmul_sva.sv ====
`default_nettype none

module matmul_sva (
    input wire logic                clk,
    input wire logic                rst,
    input wire logic                tx_ready,
    input wire matmul_pkg::result_t tx_data,
    input wire logic                load,
    input wire logic                done
);

    timeunit 1ns;
    timeprecision 1ps;

    // each handover is a single strobe
    assert property (@(posedge clk) disable iff (rst) load |=> !load)
        else $error("load stayed high for more than one cycle");

    // load is registered, so it follows tx_ready seen at the previous edge
    assert property (@(posedge clk) disable iff (rst) $rose(load) |-> $past(tx_ready))
        else $error("load rose while the transmitter was busy");

    assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else $error("done stayed high for more than one cycle");

    // output bus idles at zero between handovers
    assert property (@(posedge clk) disable iff (rst) !load |-> (tx_data == '0))
        else $error("tx_data not zero while load is low");

endmodule

bind matmul_top matmul_sva matmul_sva_i (
    .clk      (clk),
    .rst      (rst),
    .tx_ready (tx_ready),
    .tx_data  (tx_data),
    .load     (load),
    .done     (done)
);

`default_nettype wire

// ==== verification/matmul_tb.sv ====
`default_nettype none

`include "matmul_config.svh"

module matmul_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD     = 40;
    localparam int DRIVE_DELAY    = 2;
    localparam int RESET_CYCLES   = 5;
    localparam int NUM_JOBS       = 6;
    localparam int NUM_OPS        = `MATMUL_OPERAND_COUNT;
    localparam int NUM_RES        = `MATMUL_RESULT_COUNT;
    localparam int MAX_JOB_CYCLES = 130;
    // a quarter of margin over the worst job length
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_JOBS * MAX_JOB_CYCLES * 5 / 4;
    localparam int unsigned SEED  = 21855;

    logic                clk;
    logic                rst;
    logic                rx_valid;
    matmul_pkg::elem_t   rx_data;
    logic                tx_ready;
    matmul_pkg::result_t tx_data;
    logic                load;
    logic                done;

    // job table: A then B row-major, expected C row-major
    matmul_pkg::elem_t   operands [NUM_JOBS][NUM_OPS];
    matmul_pkg::result_t expected [NUM_JOBS][NUM_RES];
    int                  extra_bytes [NUM_JOBS];

    matmul_pkg::result_t got [$];
    int unsigned         done_count;
    int unsigned         cycle_count;

    matmul_top matmul_top_i (
        .clk      (clk),
        .rst      (rst),
        .rx_valid (rx_valid),
        .rx_data  (rx_data),
        .tx_ready (tx_ready),
        .tx_data  (tx_data),
        .load     (load),
        .done     (done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("=== FAIL ===");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic fill_job_table();
        // identity times B gives B back
        operands[0] = '{8'd1, 8'd0, 8'd0, 8'd1, 8'd12, 8'd34, 8'd56, 8'd78};
        expected[0] = '{18'h0000c, 18'h00022, 18'h00038, 18'h0004e};
        operands[1] = '{8'd1, 8'd2, 8'd3, 8'd4, 8'd5, 8'd6, 8'd7, 8'd8};
        expected[1] = '{18'h00013, 18'h00016, 18'h0002b, 18'h00032};
        // largest possible sum, 2*255*255
        operands[2] = '{8'd255, 8'd255, 8'd255, 8'd255, 8'd255, 8'd255, 8'd255, 8'd255};
        expected[2] = '{18'h1fc02, 18'h1fc02, 18'h1fc02, 18'h1fc02};
        operands[3] = '{8'd0, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0};
        expected[3] = '{18'h00000, 18'h00000, 18'h00000, 18'h00000};
        operands[4] = '{8'd200, 8'd17, 8'd3, 8'd99, 8'd45, 8'd250, 8'd128, 8'd7};
        expected[4] = '{18'h02ba8, 18'h0c3c7, 18'h03207, 18'h005a3};
        operands[5] = '{8'd255, 8'd128, 8'd64, 8'd2, 8'd9, 8'd255, 8'd100, 8'd31};
        expected[5] = '{18'h03af7, 18'h10d81, 18'h00308, 18'h03ffe};
        // job 4 gets stray bytes while it computes
        extra_bytes = '{0, 0, 0, 0, 3, 0};
    endtask

    // called at DRIVE_DELAY after a rising edge, returns at the same point
    task automatic send_byte(input matmul_pkg::elem_t value);
        rx_data  = value;
        rx_valid = 1'b1;
        repeat (2) @(posedge clk);
        #DRIVE_DELAY;
        rx_valid = 1'b0;
        repeat (2) @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic wait_for_done();
        while (!done) @(negedge clk);
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic check_results(input int job);
        assert (got.size() == NUM_RES) else
            stop_with_failure($sformatf("job %0d produced %0d load pulses instead of %0d",
                                        job, got.size(), NUM_RES));
        for (int k = 0; k < NUM_RES; k++) begin
            assert (got[k] == expected[job][k]) else
                stop_with_failure($sformatf(
                    "FAIL tx_data job %0d C%0d%0d: expected 0x%h, actual 0x%h",
                    job, k / 2, k % 2, expected[job][k], got[k]));
        end
        got.delete();
    endtask

    task automatic run_job(input int job);
        for (int k = 0; k < NUM_OPS; k++) begin
            send_byte(operands[job][k]);
        end
        assert (got.size() == 0) else
            stop_with_failure($sformatf("load pulse seen before the last byte of job %0d", job));
        for (int e = 0; e < extra_bytes[job]; e++) begin
            send_byte(8'hee ^ 8'(e));
        end
        wait_for_done();
        check_results(job);
    endtask

    // transmitter model, busy for a random while after each handover
    initial begin : tx_peer
        int unsigned hold;
        tx_ready = 1'b1;
        void'($urandom(SEED));
        forever begin
            @(negedge clk);
            if (load) begin
                hold = $urandom_range(4, 1);
                @(posedge clk);
                #DRIVE_DELAY;
                tx_ready = 1'b0;
                repeat (hold) @(posedge clk);
                #DRIVE_DELAY;
                tx_ready = 1'b1;
            end
        end
    end

    // capture every handover on the output bus, busy window included
    always @(negedge clk) begin
        if (load) begin
            assert (tx_ready) else
                stop_with_failure("load pulse arrived while the transmitter was busy");
            got.push_back(tx_data);
        end
    end

    always @(negedge clk) begin
        if (done) begin
            done_count <= done_count + 1;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        stop_with_failure($sformatf("timeout after %0d cycles without finishing all jobs",
                                    TIMEOUT_CYCLES));
    end

    initial begin
        rst      = 1'b1;
        rx_valid = 1'b0;
        rx_data  = '0;
        fill_job_table();
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
        for (int j = 0; j < NUM_JOBS; j++) begin
            run_job(j);
        end
        assert (done_count == NUM_JOBS) else
            stop_with_failure($sformatf("saw %0d done pulses for %0d jobs",
                                        done_count, NUM_JOBS));
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire
